/* Makefile */
# Verilator build and run of the vector load/store unit testbench

TOP := tb_vlsu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlsu_top.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* design/vlsu_defs.svh */
/*
 * Vector load/store unit size definitions
 * Data, register file and identifier widths shared by package and RTL
 */

`ifndef VLSU_DEFS_SVH
`define VLSU_DEFS_SVH

// One data word on the bus and in the register file
`define VLSU_ELEN     32
`define VLSU_ELENB    4

// Bytes per vector register, also the largest transfer of one instruction
`define VLSU_VLENB    32
`define VLSU_NR_VREGS 32

// Register number in the upper bits, word within the register below
`define VLSU_VRF_AW   8
`define VLSU_ID_W     3

`endif

/* design/vlsu_elem_seq.sv */
/*
 * Element sequencer of the vector load/store unit
 * Walks the elements of the active instruction and builds one command each
 */

`timescale 1ns/1ps
`default_nettype none

`include "vlsu_defs.svh"

module vlsu_elem_seq (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  vlsu_pkg::vlsu_req_t req_i,
  input  logic                start_i,
  output vlsu_pkg::elem_cmd_t cmd_o,
  output logic                cmd_valid_o,
  input  logic                cmd_ready_i
);
  import vlsu_pkg::*;

  localparam int unsigned lane_w     = $clog2(`VLSU_ELENB);
  localparam int unsigned byte_pos_w = $clog2(`VLSU_VLENB);

  vl_t                   idx_q;
  logic                  fire;
  logic                  strided;
  word_t                 elem_bytes;
  word_t                 stride;
  word_t                 mem_addr;
  logic [byte_pos_w-1:0] byte_pos;

  ////////////////////
  // Element counter
  ////////////////////

  // The counter still holds the old index during the start cycle
  assign cmd_valid_o = !start_i && (idx_q < req_i.vl);
  assign fire        = cmd_valid_o && cmd_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idx_q <= '0;
    end else if (start_i) begin
      idx_q <= '0;
    end else if (fire) begin
      idx_q <= idx_q + vl_t'(1);
    end
  end

  ////////////////////
  // Address generation
  ////////////////////

  assign strided    = (req_i.op == VLSE) || (req_i.op == VSSE);
  assign elem_bytes = word_t'(1) << req_i.vsew;
  // Unit stride steps by the element size, strided ops by rs2 in bytes
  assign stride     = strided ? req_i.rs2 : elem_bytes;
  assign mem_addr   = req_i.rs1 + word_t'(idx_q) * stride;

  // Elements are packed from byte 0 of register vd upwards
  assign byte_pos = byte_pos_w'(idx_q << req_i.vsew);

  always_comb begin
    cmd_o.mem_adr  = mem_addr[`VLSU_ELEN-1:lane_w];
    cmd_o.mem_lane = mem_addr[lane_w-1:0];
    cmd_o.vrf_addr = {req_i.vd, byte_pos[byte_pos_w-1:lane_w]};
    cmd_o.vrf_lane = byte_pos[lane_w-1:0];
    cmd_o.vsew     = req_i.vsew;
    cmd_o.is_load  = (req_i.op == VLE) || (req_i.op == VLSE);
    cmd_o.last     = (idx_q + vl_t'(1)) == req_i.vl;
  end

endmodule

`default_nettype wire

/* design/vlsu_mem_port.sv */
/*
 * Memory port of the vector load/store unit
 * Moves one element at a time between the register file and Wishbone
 */

`timescale 1ns/1ps
`default_nettype none

`include "vlsu_defs.svh"

module vlsu_mem_port (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  vlsu_pkg::elem_cmd_t cmd_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  output logic                done_o,
  output vlsu_pkg::vrf_wr_t   vrf_wr_o,
  output logic                vrf_we_o,
  output vlsu_pkg::vrf_addr_t vrf_raddr_o,
  output logic                vrf_re_o,
  input  vlsu_pkg::word_t     vrf_rdata_i,
  output vlsu_pkg::wb_req_t   wb_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  input  vlsu_pkg::word_t     wb_dat_i,
  input  logic                wb_ack_i
);
  import vlsu_pkg::*;

  typedef enum logic [1:0] {IDLE, VRF_READ, BUS, VRF_WRITE} state_e;

  state_e    state_q;
  state_e    state_d;
  elem_cmd_t cmd_q;
  word_t     wdat_q;
  word_t     ld_q;
  logic      rd_pend_q;
  logic      bus_done;
  lane_t     ld_shift;
  lane_t     st_shift;
  word_t     st_data;

  // Byte mask of one element before it is moved to its lane
  function automatic be_t elem_mask(vsew_e ew);
    case (ew)
      EW_8:    elem_mask = be_t'(4'b0001);
      EW_16:   elem_mask = be_t'(4'b0011);
      default: elem_mask = '1;
    endcase
  endfunction

  function automatic word_t rotl_bytes(word_t data, lane_t amount);
    logic [2*`VLSU_ELEN-1:0] dbl;
    dbl = {data, data} << (8 * amount);
    return dbl[2*`VLSU_ELEN-1 -: `VLSU_ELEN];
  endfunction

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cmd_valid_i) begin
          state_d = cmd_i.is_load ? BUS : VRF_READ;
        end
      end
      VRF_READ:  state_d = BUS;
      BUS: begin
        if (wb_ack_i) begin
          state_d = cmd_q.is_load ? VRF_WRITE : IDLE;
        end
      end
      VRF_WRITE: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      rd_pend_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // Read data arrives in the first bus cycle of a store
      rd_pend_q <= (state_q == VRF_READ);
    end
  end

  ////////////////////
  // Data path
  ////////////////////

  assign bus_done = (state_q == BUS) && wb_ack_i;
  assign ld_shift = cmd_q.vrf_lane - cmd_q.mem_lane;
  assign st_shift = cmd_q.mem_lane - cmd_q.vrf_lane;
  assign st_data  = rotl_bytes(vrf_rdata_i, st_shift);

  always_ff @(posedge clk_i) begin
    if (cmd_ready_o && cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
    if (rd_pend_q) begin
      wdat_q <= st_data;
    end
    if (bus_done && cmd_q.is_load) begin
      ld_q <= rotl_bytes(wb_dat_i, ld_shift);
    end
  end

  assign cmd_ready_o = (state_q == IDLE);
  assign vrf_re_o    = (state_q == VRF_READ);
  assign vrf_raddr_o = cmd_q.vrf_addr;
  assign vrf_we_o    = (state_q == VRF_WRITE);
  assign vrf_wr_o    = '{addr: cmd_q.vrf_addr,
                         data: ld_q,
                         be:   elem_mask(cmd_q.vsew) << cmd_q.vrf_lane};

  // Store data bypasses the capture register in the first bus cycle
  assign wb_o     = '{adr: {cmd_q.mem_adr, lane_t'(0)},
                      dat: rd_pend_q ? st_data : wdat_q,
                      sel: elem_mask(cmd_q.vsew) << cmd_q.mem_lane,
                      we:  !cmd_q.is_load};
  assign wb_cyc_o = (state_q == BUS);
  assign wb_stb_o = (state_q == BUS);

  assign done_o = cmd_q.last && (vrf_we_o || (bus_done && !cmd_q.is_load));

endmodule

`default_nettype wire

/* design/vlsu_pkg.sv */
/*
 * Vector load/store unit types
 * Opcodes, element widths and the structs passed between the stages
 */

`default_nettype none

`include "vlsu_defs.svh"

package vlsu_pkg;

  typedef logic [`VLSU_ELEN-1:0]                     word_t;
  typedef logic [`VLSU_ELENB-1:0]                    be_t;
  typedef logic [$clog2(`VLSU_ELENB)-1:0]            lane_t;
  typedef logic [`VLSU_ELEN-$clog2(`VLSU_ELENB)-1:0] word_adr_t;
  typedef logic [`VLSU_ID_W-1:0]                     id_t;
  typedef logic [$clog2(`VLSU_NR_VREGS)-1:0]         vreg_t;
  // Element count, one extra bit so a full register of bytes fits
  typedef logic [$clog2(`VLSU_VLENB):0]              vl_t;
  typedef logic [`VLSU_VRF_AW-1:0]                   vrf_addr_t;

  typedef enum logic [1:0] {VLE, VSE, VLSE, VSSE} vlsu_op_e;
  typedef enum logic [1:0] {EW_8, EW_16, EW_32} vsew_e;

  typedef struct packed {
    id_t      id;
    vlsu_op_e op;
    vsew_e    vsew;
    vreg_t    vd;
    vl_t      vl;
    word_t    rs1;
    word_t    rs2;
  } vlsu_req_t;

  typedef struct packed {
    id_t   id;
    vreg_t vd;
  } vlsu_rsp_t;

  // One element transfer between memory and register file
  typedef struct packed {
    word_adr_t mem_adr;
    lane_t     mem_lane;
    vrf_addr_t vrf_addr;
    lane_t     vrf_lane;
    vsew_e     vsew;
    logic      is_load;
    logic      last;
  } elem_cmd_t;

  typedef struct packed {
    word_t adr;
    word_t dat;
    be_t   sel;
    logic  we;
  } wb_req_t;

  typedef struct packed {
    vrf_addr_t addr;
    word_t     data;
    be_t       be;
  } vrf_wr_t;

endpackage

`default_nettype wire

/* design/vlsu_req_stage.sv */
/*
 * Request stage of the vector load/store unit
 * Accepts one instruction, holds it while busy and returns the response
 */

`timescale 1ns/1ps
`default_nettype none

module vlsu_req_stage (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  vlsu_pkg::vlsu_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                done_i,
  output vlsu_pkg::vlsu_req_t active_req_o,
  output logic                start_o,
  output vlsu_pkg::vlsu_rsp_t rsp_o,
  output logic                rsp_valid_o
);
  import vlsu_pkg::*;

  vlsu_req_t active_q;
  vlsu_rsp_t rsp_q;
  logic      init_q;
  logic      busy_q;
  logic      start_q;
  logic      rsp_valid_q;
  logic      accept;

  // Not ready until the first clock after reset
  assign req_ready_o = init_q && !busy_q;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      init_q      <= 1'b0;
      busy_q      <= 1'b0;
      start_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
      active_q    <= '0;
    end else begin
      init_q      <= 1'b1;
      start_q     <= accept;
      rsp_valid_q <= done_i;
      if (accept) begin
        active_q <= req_i;
        // Empty instructions never become busy
        busy_q   <= (req_i.vl != '0);
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_i) begin
      rsp_q <= '{id: active_q.id, vd: active_q.vd};
    end
  end

  assign active_req_o = active_q;
  assign start_o      = start_q;
  assign rsp_o        = rsp_q;
  assign rsp_valid_o  = rsp_valid_q;

endmodule

`default_nettype wire

/* design/vlsu_top.sv */
/*
 * Vector load/store unit top level
 * Request stage, element sequencer and memory port in a chain
 */

`timescale 1ns/1ps
`default_nettype none

module vlsu_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Controller
  input  vlsu_pkg::vlsu_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output vlsu_pkg::vlsu_rsp_t rsp_o,
  output logic                rsp_valid_o,
  // Register file
  output vlsu_pkg::vrf_wr_t   vrf_wr_o,
  output logic                vrf_we_o,
  output vlsu_pkg::vrf_addr_t vrf_raddr_o,
  output logic                vrf_re_o,
  input  vlsu_pkg::word_t     vrf_rdata_i,
  // Wishbone master
  output vlsu_pkg::wb_req_t   wb_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  input  vlsu_pkg::word_t     wb_dat_i,
  input  logic                wb_ack_i
);
  import vlsu_pkg::*;

  vlsu_req_t active_req;
  elem_cmd_t cmd;
  logic      start;
  logic      done;
  logic      cmd_valid;
  logic      cmd_ready;

  vlsu_req_stage u_req_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .done_i      (done),
    .active_req_o(active_req),
    .start_o     (start),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o)
  );

  vlsu_elem_seq u_elem_seq (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (active_req),
    .start_i    (start),
    .cmd_o      (cmd),
    .cmd_valid_o(cmd_valid),
    .cmd_ready_i(cmd_ready)
  );

  vlsu_mem_port u_mem_port (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd_i      (cmd),
    .cmd_valid_i(cmd_valid),
    .cmd_ready_o(cmd_ready),
    .done_o     (done),
    .vrf_wr_o   (vrf_wr_o),
    .vrf_we_o   (vrf_we_o),
    .vrf_raddr_o(vrf_raddr_o),
    .vrf_re_o   (vrf_re_o),
    .vrf_rdata_i(vrf_rdata_i),
    .wb_o       (wb_o),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i)
  );

endmodule

`default_nettype wire

/* test/tb_vlsu.sv */
/*
 * Testbench for the vector load/store unit
 * Random instructions against Wishbone memory and register file models
 */

`timescale 1ns/1ps
`default_nettype none

`include "vlsu_defs.svh"

module tb_vlsu;
  import vlsu_pkg::*;

  localparam int mem_bytes = 1024;
  localparam int vrf_bytes = `VLSU_NR_VREGS * `VLSU_VLENB;

  logic      clk_i;
  logic      arst_n_i;
  vlsu_req_t req_i;
  logic      req_valid_i;
  logic      req_ready_o;
  vlsu_rsp_t rsp_o;
  logic      rsp_valid_o;
  vrf_wr_t   vrf_wr_o;
  logic      vrf_we_o;
  vrf_addr_t vrf_raddr_o;
  logic      vrf_re_o;
  word_t     vrf_rdata_i;
  wb_req_t   wb_o;
  logic      wb_cyc_o;
  logic      wb_stb_o;
  word_t     wb_dat_i;
  logic      wb_ack_i;

  logic [7:0]  mem     [mem_bytes];
  logic [7:0]  exp_mem [mem_bytes];
  logic [7:0]  vrf     [vrf_bytes];
  logic [7:0]  exp_vrf [vrf_bytes];
  logic [31:0] lfsr_q;
  int          ack_delays[$];
  int          bus_cnt;
  int          rsp_cnt;
  int          wait_cnt;
  logic        in_cycle;
  logic        rdata_hold;
  wb_req_t     cycle_req;

  vlsu_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp));
    end
  endtask

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [7:0] fill_byte(input int idx, input logic [7:0] salt);
    return 8'((idx * 29) ^ (idx >> 5)) ^ salt;
  endfunction

  ////////////////////
  // Wishbone memory model
  ////////////////////

  always @(negedge clk_i) begin
    int base;
    base = int'({wb_o.adr[9:2], 2'b00});
    if (wb_ack_i) begin
      // Master must release the bus in the cycle after ack
      check_eq("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
      wb_ack_i <= 1'b0;
    end else if (wb_cyc_o || wb_stb_o) begin
      if (!in_cycle) begin
        in_cycle  = 1'b1;
        cycle_req = wb_o;
        wait_cnt  = (ack_delays.size() > 0) ? ack_delays.pop_front() : 0;
        bus_cnt++;
        check_eq("wb_o.adr", wb_o.adr & 32'hffff_fc03, 32'd0);
      end
      check_eq("wb_stb_o", 32'(wb_stb_o), 32'(wb_cyc_o));
      check_eq("wb_o.adr", wb_o.adr, cycle_req.adr);
      check_eq("wb_o.dat", wb_o.dat, cycle_req.dat);
      check_eq("wb_o.sel", 32'(wb_o.sel), 32'(cycle_req.sel));
      check_eq("wb_o.we", 32'(wb_o.we), 32'(cycle_req.we));
      if (wait_cnt == 0) begin
        for (int k = 0; k < 4; k++) begin
          if (wb_o.we && wb_o.sel[k]) begin
            mem[base + k] = wb_o.dat[8*k +: 8];
          end
        end
        wb_dat_i <= {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
        wb_ack_i <= 1'b1;
        in_cycle  = 1'b0;
      end else begin
        wait_cnt--;
      end
    end else if (in_cycle) begin
      stop_run("Wishbone cycle was dropped before ack");
    end
  end

  ////////////////////
  // Register file model
  ////////////////////

  always @(negedge clk_i) begin
    int ra;
    ra = int'(vrf_raddr_o) * 4;
    if (vrf_we_o) begin
      for (int k = 0; k < 4; k++) begin
        if (vrf_wr_o.be[k]) begin
          vrf[int'(vrf_wr_o.addr) * 4 + k] = vrf_wr_o.data[8*k +: 8];
        end
      end
    end
    // Read data covers the cycle after the read, junk once that cycle is over
    if (vrf_re_o) begin
      vrf_rdata_i <= {vrf[ra + 3], vrf[ra + 2], vrf[ra + 1], vrf[ra]};
      rdata_hold  <= 1'b1;
    end else if (rdata_hold) begin
      rdata_hold <= 1'b0;
    end else begin
      vrf_rdata_i <= 32'hdead_beef;
    end
  end

  always @(negedge clk_i) begin
    if (rsp_valid_o) begin
      rsp_cnt++;
    end
  end

  // vl_force below zero picks a random vl, otherwise it is capped at a full register
  task automatic make_req(input vlsu_op_e op, input vsew_e ew, input int vl_force,
                          output vlsu_req_t r);
    logic [31:0] v;
    int          ebytes;
    int          max_vl;
    ebytes = 1 << ew;
    max_vl = `VLSU_VLENB / ebytes;
    r.op   = op;
    r.vsew = ew;
    draw_bits(3, v);
    r.id = id_t'(v);
    draw_bits(5, v);
    r.vd = vreg_t'(v);
    draw_bits(6, v);
    if (vl_force < 0) begin
      r.vl = vl_t'(int'(v) % (max_vl + 1));
    end else begin
      r.vl = vl_t'((vl_force < max_vl) ? vl_force : max_vl);
    end
    // Base in the lower half of memory so every stride stays inside it
    draw_bits(9, v);
    r.rs1 = v & ~32'(ebytes - 1);
    draw_bits(4, v);
    r.rs2 = v * 32'(ebytes);
  endtask

  task automatic run_instr(input vlsu_req_t r);
    int          ebytes;
    int          stride;
    int          addr;
    int          pos;
    int          cycles;
    logic [31:0] d;
    ebytes = 1 << r.vsew;
    stride = (r.op == VLSE || r.op == VSSE) ? int'(r.rs2) : ebytes;
    // Reference model, one element at a time
    for (int i = 0; i < int'(r.vl); i++) begin
      addr = int'(r.rs1) + i * stride;
      pos  = int'(r.vd) * `VLSU_VLENB + i * ebytes;
      for (int b = 0; b < ebytes; b++) begin
        if (r.op == VLE || r.op == VLSE) begin
          exp_vrf[pos + b] = exp_mem[addr + b];
        end else begin
          exp_mem[addr + b] = exp_vrf[pos + b];
        end
      end
      draw_bits(2, d);
      ack_delays.push_back(int'(d));
    end
    bus_cnt = 0;
    rsp_cnt = 0;
    cycles  = 0;
    while (!req_ready_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 20) begin
        stop_run("Timeout waiting for req_ready_o before a request");
      end
    end
    req_i       = r;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    if (r.vl != '0) begin
      cycles = 0;
      while (!rsp_valid_o) begin
        check_eq("req_ready_o", 32'(req_ready_o), 32'd0);
        @(negedge clk_i);
        cycles++;
        if (cycles > 500) begin
          stop_run("Timeout waiting for rsp_valid_o");
        end
      end
      check_eq("rsp_o.id", 32'(rsp_o.id), 32'(r.id));
      check_eq("rsp_o.vd", 32'(rsp_o.vd), 32'(r.vd));
      check_eq("req_ready_o", 32'(req_ready_o), 32'd1);
    end
    repeat (3) @(negedge clk_i);
    check_eq("bus cycles", 32'(bus_cnt), 32'(r.vl));
    check_eq("rsp_valid_o pulses", 32'(rsp_cnt), (r.vl != '0) ? 32'd1 : 32'd0);
    check_eq("req_ready_o", 32'(req_ready_o), 32'd1);
    for (int a = 0; a < mem_bytes; a++) begin
      check_eq($sformatf("mem[%0d]", a), 32'(mem[a]), 32'(exp_mem[a]));
    end
    for (int a = 0; a < vrf_bytes; a++) begin
      check_eq($sformatf("vrf[%0d]", a), 32'(vrf[a]), 32'(exp_vrf[a]));
    end
  endtask

  initial begin
    vlsu_req_t   r;
    logic [31:0] op_bits;
    logic [31:0] ew_bits;
    arst_n_i    = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    vrf_rdata_i = '0;
    wb_dat_i    = '0;
    wb_ack_i    = 1'b0;
    lfsr_q      = 32'd40;
    bus_cnt     = 0;
    rsp_cnt     = 0;
    wait_cnt    = 0;
    in_cycle    = 1'b0;
    rdata_hold  = 1'b0;
    cycle_req   = '0;
    for (int a = 0; a < mem_bytes; a++) begin
      mem[a]     = fill_byte(a, 8'h5a);
      exp_mem[a] = mem[a];
      vrf[a]     = fill_byte(a, 8'hc3);
      exp_vrf[a] = vrf[a];
    end
    repeat (2) @(negedge clk_i);
    check_eq("req_ready_o", 32'(req_ready_o), 32'd0);
    check_eq("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    check_eq("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
    check_eq("wb_stb_o", 32'(wb_stb_o), 32'd0);
    check_eq("vrf_we_o", 32'(vrf_we_o), 32'd0);
    check_eq("vrf_re_o", 32'(vrf_re_o), 32'd0);
    arst_n_i = 1'b1;

    // Every opcode at every width, long vectors
    for (int e = 0; e < 3; e++) begin
      for (int o = 0; o < 4; o++) begin
        make_req(vlsu_op_e'(o), vsew_e'(e), 31, r);
        run_instr(r);
      end
    end

    // Random mix
    for (int n = 0; n < 60; n++) begin
      draw_bits(2, op_bits);
      draw_bits(2, ew_bits);
      make_req(vlsu_op_e'(op_bits[1:0]), vsew_e'(2'(ew_bits % 3)), -1, r);
      run_instr(r);
    end

    // Empty instruction, no bus cycle and no response
    make_req(VSE, EW_32, 0, r);
    run_instr(r);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* vlsu_top.f */
+incdir+design
design/vlsu_pkg.sv
design/vlsu_req_stage.sv
design/vlsu_elem_seq.sv
design/vlsu_mem_port.sv
design/vlsu_top.sv
test/tb_vlsu.sv
